//--- logic/nnPkg.sv
package nnPkg;
	localparam int actWidth = 8;
	localparam int accWidth = 23;
	localparam int biasWidth = 16;
	localparam int fracBits = 6; // Bit fracBits-1 rounds half up.
	localparam int actMax = 127;

	localparam int numInputs = 8;
	localparam int numHidden = 6;
	localparam int numOutputs = 3;

	localparam int inputDepth = 4; // Also the sender's starting credits.
	localparam int outputDepth = 4;
	localparam int consumerCredits = 2;

	// Neuron-major order. Neuron 0 weight 0 sits in the lowest byte.
	localparam logic [numHidden*numInputs*actWidth-1:0] hiddenWeights = {
		8'sd12, -8'sd8, 8'sd30, 8'sd4, -8'sd22, 8'sd16, 8'sd10, 8'sd6,
		-8'sd14, 8'sd26, 8'sd8, 8'sd18, 8'sd2, -8'sd30, 8'sd20, 8'sd12,
		8'sd40, 8'sd10, -8'sd6, 8'sd14, 8'sd22, 8'sd8, -8'sd18, 8'sd28,
		8'sd6, 8'sd34, -8'sd26, 8'sd12, 8'sd16, 8'sd10, 8'sd24, -8'sd4,
		-8'sd10, 8'sd18, 8'sd20, -8'sd12, 8'sd36, 8'sd6, 8'sd14, 8'sd32,
		8'sd16, 8'sd44, 8'sd12, -8'sd50, 8'sd18, 8'sd26, 8'sd6, 8'sd20
	};

	localparam logic [numHidden*biasWidth-1:0] hiddenBiases = {
		-16'sd96, 16'sd32, 16'sd0, 16'sd64, -16'sd40, 16'sd128
	};

	localparam logic [numOutputs*numHidden*actWidth-1:0] outputWeights = {
		8'sd22, -8'sd18, 8'sd30, 8'sd12, 8'sd40, -8'sd8,
		8'sd14, 8'sd36, -8'sd20, 8'sd26, 8'sd10, 8'sd18,
		8'sd32, 8'sd8, 8'sd24, -8'sd14, 8'sd20, 8'sd44
	};

	localparam logic [numOutputs*biasWidth-1:0] outputBiases = {16'sd16, -16'sd64, 16'sd0};
endpackage

//--- logic/neuronNode.sv
`timescale 1ns/1ns

module neuronNode #(
	parameter int numIn = 8,
	parameter logic [numIn*nnPkg::actWidth-1:0] weights = '0,
	parameter logic signed [nnPkg::biasWidth-1:0] bias = '0
) (
	input logic clk,
	input logic reset,
	input logic [numIn*nnPkg::actWidth-1:0] activations,
	output logic [nnPkg::actWidth-1:0] result
);
	import nnPkg::*;

	localparam int roundWidth = accWidth - fracBits;

	logic signed [actWidth-1:0] actReg [numIn];
	logic signed [accWidth-1:0] sumNext;
	logic signed [accWidth-1:0] sum;
	logic [roundWidth-1:0] rounded;

	// Stage one.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < numIn; i++)
				actReg[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < numIn; i++)
				actReg[i] <= activations[i*actWidth +: actWidth];
		end
	end

	always_comb
	begin
		sumNext = {{(accWidth - biasWidth){bias[biasWidth-1]}}, bias}; // Bias sign-extended.
		for (int i = 0; i < numIn; i++)
			sumNext = sumNext + actReg[i] * $signed(weights[i*actWidth +: actWidth]);
	end

	// Drop the fraction and add the half bit.
	assign rounded = sum[accWidth-1:fracBits] + roundWidth'(sum[fracBits-1]);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sum <= '0;
			result <= '0;
		end
		else
		begin
			sum <= sumNext;
			if (sum[accWidth-1])
				result <= '0; // Rectifier.
			else if (rounded > roundWidth'(actMax))
				result <= actWidth'(actMax); // Covers a round-up to 128 too.
			else
				result <= rounded[actWidth-1:0];
		end
	end
endmodule

//--- logic/denseLayer.sv
`timescale 1ns/1ns

module denseLayer #(
	parameter int numIn = 8,
	parameter int numOut = 6,
	parameter logic [numOut*numIn*nnPkg::actWidth-1:0] weights = '0,
	parameter logic [numOut*nnPkg::biasWidth-1:0] biases = '0
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [numIn*nnPkg::actWidth-1:0] inVector,
	output logic outValid,
	output logic [numOut*nnPkg::actWidth-1:0] outVector
);
	import nnPkg::*;

	logic [2:0] validPipe; // Tracks the three neuron stages.

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[1:0], inValid};
	end

	assign outValid = validPipe[2];

	for (genvar n = 0; n < numOut; n++)
	begin : gNeuron
		neuronNode #(
			.numIn(numIn),
			.weights(weights[n*numIn*actWidth +: numIn*actWidth]),
			.bias(biases[n*biasWidth +: biasWidth])
		) node (
			.clk(clk),
			.reset(reset),
			.activations(inVector),
			.result(outVector[n*actWidth +: actWidth])
		);
	end

	validKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(outValid))
		else $error("denseLayer outValid unknown after reset");
endmodule

//--- logic/inputQueue.sv
`timescale 1ns/1ns

module inputQueue #(
	parameter int depth = 4,
	parameter int width = 64
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic [width-1:0] pushData,
	input logic room,
	output logic popValid,
	output logic [width-1:0] popData,
	output logic credit
);
	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntWidth = $clog2(depth + 1);

	logic [width-1:0] mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count;

	assign popValid = (count != '0) && room; // Downstream has space for one more.
	assign popData = mem[rdPtr];
	assign credit = popValid; // One credit back per pop.

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (popValid)
				rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + cntWidth'(push) - cntWidth'(popValid);
		end
	end

	// Sender must hold a credit for every push.
	noOverrun: assert property (@(posedge clk) disable iff (reset)
		push |-> count != cntWidth'(depth))
		else $error("inputQueue push while full");
endmodule

//--- logic/outputStage.sv
`timescale 1ns/1ns

module outputStage #(
	parameter int depth = 4,
	parameter int width = 24,
	parameter int credits = 2
) (
	input logic clk,
	input logic reset,
	input logic pop,
	input logic resValid,
	input logic [width-1:0] resData,
	input logic outCredit,
	output logic room,
	output logic outValid,
	output logic [width-1:0] outVector
);
	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntWidth = $clog2(depth + 1);
	localparam int credWidth = $clog2(credits + 1);

	logic [width-1:0] mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count;
	logic [cntWidth-1:0] inFlight; // Popped upstream, not yet written.
	logic [credWidth-1:0] creditCnt;

	assign room = (int'(count) + int'(inFlight)) < depth;
	assign outValid = (count != '0) && (creditCnt != '0);
	assign outVector = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (resValid)
			mem[wrPtr] <= resData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			inFlight <= '0;
			creditCnt <= credWidth'(credits); // Consumer buffer starts empty.
		end
		else
		begin
			if (resValid)
				wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (outValid)
				rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + cntWidth'(resValid) - cntWidth'(outValid);
			inFlight <= inFlight + cntWidth'(pop) - cntWidth'(resValid);
			creditCnt <= creditCnt + credWidth'(outCredit) - credWidth'(outValid);
		end
	end

	noOverflow: assert property (@(posedge clk) disable iff (reset)
		resValid |-> count != cntWidth'(depth))
		else $error("outputStage FIFO overflow");

	creditBound: assert property (@(posedge clk) disable iff (reset)
		creditCnt <= credWidth'(credits))
		else $error("outputStage consumer returned too many credits");
endmodule

//--- logic/neuralNet.sv
`timescale 1ns/1ns

module neuralNet (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [nnPkg::numInputs*nnPkg::actWidth-1:0] inVector,
	input logic outCredit,
	output logic inCredit,
	output logic outValid,
	output logic [nnPkg::numOutputs*nnPkg::actWidth-1:0] outVector
);
	import nnPkg::*;

	logic room;
	logic popValid;
	logic [numInputs*actWidth-1:0] popData;
	logic hidValid;
	logic [numHidden*actWidth-1:0] hidVector;
	logic resValid;
	logic [numOutputs*actWidth-1:0] resVector;

	inputQueue #(.depth(inputDepth), .width(numInputs*actWidth)) queue (
		.clk(clk),
		.reset(reset),
		.push(inValid),
		.pushData(inVector),
		.room(room),
		.popValid(popValid),
		.popData(popData),
		.credit(inCredit)
	);

	denseLayer #(
		.numIn(numInputs),
		.numOut(numHidden),
		.weights(hiddenWeights),
		.biases(hiddenBiases)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(popValid),
		.inVector(popData),
		.outValid(hidValid),
		.outVector(hidVector)
	);

	denseLayer #(
		.numIn(numHidden),
		.numOut(numOutputs),
		.weights(outputWeights),
		.biases(outputBiases)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hidValid),
		.inVector(hidVector),
		.outValid(resValid),
		.outVector(resVector)
	);

	// Pop to write is six cycles.
	outputStage #(
		.depth(outputDepth),
		.width(numOutputs*actWidth),
		.credits(consumerCredits)
	) stage (
		.clk(clk),
		.reset(reset),
		.pop(popValid),
		.resValid(resValid),
		.resData(resVector),
		.outCredit(outCredit),
		.room(room),
		.outValid(outValid),
		.outVector(outVector)
	);
endmodule

//--- verification/neuralNetModel.svh
`ifndef NEURAL_NET_MODEL_SVH
`define NEURAL_NET_MODEL_SVH

// Rectify, round half up, saturate.
function automatic logic [nnPkg::actWidth-1:0] modelActivate(input longint sum);
	longint rounded;
	if (sum <= 0)
		return '0;
	rounded = (sum >>> nnPkg::fracBits) + ((sum >>> (nnPkg::fracBits - 1)) & 1);
	if (rounded > nnPkg::actMax)
		return nnPkg::actWidth'(nnPkg::actMax);
	return nnPkg::actWidth'(rounded);
endfunction

function automatic logic [nnPkg::actWidth-1:0] modelNeuron(
	input logic [nnPkg::numInputs*nnPkg::actWidth-1:0] acts,
	input int numIn,
	input logic [nnPkg::numHidden*nnPkg::numInputs*nnPkg::actWidth-1:0] weights,
	input int neuron,
	input logic signed [nnPkg::biasWidth-1:0] bias);
	longint sum;
	sum = bias;
	for (int i = 0; i < numIn; i++)
		sum += longint'($signed(acts[i*nnPkg::actWidth +: nnPkg::actWidth]))
			* longint'($signed(weights[(neuron*numIn + i)*nnPkg::actWidth +: nnPkg::actWidth]));
	return modelActivate(sum);
endfunction

function automatic logic [nnPkg::numOutputs*nnPkg::actWidth-1:0] modelNet(
	input logic [nnPkg::numInputs*nnPkg::actWidth-1:0] vec);
	logic [nnPkg::numHidden*nnPkg::actWidth-1:0] hidden;
	logic [nnPkg::numOutputs*nnPkg::actWidth-1:0] result;
	for (int n = 0; n < nnPkg::numHidden; n++)
		hidden[n*nnPkg::actWidth +: nnPkg::actWidth] = modelNeuron(vec, nnPkg::numInputs,
			nnPkg::hiddenWeights, n, nnPkg::hiddenBiases[n*nnPkg::biasWidth +: nnPkg::biasWidth]);
	for (int n = 0; n < nnPkg::numOutputs; n++)
		result[n*nnPkg::actWidth +: nnPkg::actWidth] = modelNeuron(hidden, nnPkg::numHidden,
			nnPkg::outputWeights, n, nnPkg::outputBiases[n*nnPkg::biasWidth +: nnPkg::biasWidth]);
	return result;
endfunction

`endif

//--- verification/neuralNetTb.sv
`timescale 1ns/1ns

module neuralNetTb;
	import nnPkg::*;

	`include "neuralNetModel.svh"

	localparam int plannedVectors = 88; // 11 + 5 + 4 + 8 + 60.
	localparam int cycleLimit = 40 * plannedVectors + 200;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic inValid = 1'b0;
	logic [numInputs*actWidth-1:0] inVector = '0;
	logic outCredit = 1'b0;
	logic inCredit;
	logic outValid;
	logic [numOutputs*actWidth-1:0] outVector;

	logic [numOutputs*actWidth-1:0] expQ [$];
	logic [numOutputs*actWidth-1:0] expHead = 'x;
	int expCount = 0;
	int sendCredits = inputDepth;
	int sent = 0;
	int creditPulses = 0;
	int beats = 0;
	int creditsGiven = 0;
	int owed = 0; // Credits the consumer has yet to return.
	int cycles = 0;
	int errors = 0;
	int errorsAtStart = 0;
	int passCount = 0;
	int failCount = 0;
	integer seed = 32'he48a_d8bf;
	bit holdCredits = 1'b0;
	bit randomCredits = 1'b0;
	bit giveCredit = 1'b0;
	string testName = "resetState";

	neuralNet UUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inVector(inVector),
		.outCredit(outCredit),
		.inCredit(inCredit),
		.outValid(outValid),
		.outVector(outVector)
	);

	always #5 clk = ~clk;

	// Beat, credit and scoreboard bookkeeping.
	always @(posedge clk)
	begin
		cycles++;
		if (reset)
			sendCredits = inputDepth;
		else
		begin
			if (outValid)
			begin
				beats++;
				if (expQ.size() > 0)
					void'(expQ.pop_front());
			end
			if (outCredit)
				creditsGiven++;
			if (inCredit)
				creditPulses++;
			sendCredits = sendCredits + int'(inCredit) - int'(inValid);
		end
		expCount = expQ.size();
		expHead = (expQ.size() > 0) ? expQ[0] : 'x;
	end

	always @(posedge clk)
	begin
		if (cycles >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, %0d results still missing", cycles, expQ.size());
			$display("Verification failed");
			$finish;
		end
	end

	// Consumer frees one buffer slot per cycle at most.
	always @(posedge clk)
	begin
		if (!reset && outValid)
			owed++;
		giveCredit = !reset && !holdCredits && (!randomCredits || ($random(seed) & 1));
		#1;
		outCredit = 1'b0;
		if (giveCredit && owed > 0)
		begin
			outCredit = 1'b1;
			owed--;
		end
	end

	resetQuiet: assert property (@(negedge clk) reset |-> !outValid && !inCredit)
		else
		begin
			errors++;
			$display("%s: outValid or inCredit high during reset", testName);
		end

	firstCycleQuiet: assert property (@(negedge clk) $fell(reset) |-> !outValid && !inCredit)
		else
		begin
			errors++;
			$display("%s: outValid or inCredit high right after reset", testName);
		end

	resultExpected: assert property (@(negedge clk) disable iff (reset) outValid |-> expCount > 0)
		else
		begin
			errors++;
			$display("%s: a result came out with none expected", testName);
		end

	resultMatch: assert property (@(negedge clk) disable iff (reset)
		outValid && expCount > 0 |-> outVector == expHead)
		else
		begin
			errors++;
			$display("ERROR %s: expected %h actual %h", testName, expHead, outVector);
		end

	senderCredits: assert property (@(negedge clk) sendCredits >= 0 && sendCredits <= inputDepth)
		else
		begin
			errors++;
			$display("%s: the sender's credit count left the range 0 to %0d", testName,
				inputDepth);
		end

	consumerBeats: assert property (@(negedge clk) disable iff (reset)
		beats <= creditsGiven + nnPkg::consumerCredits)
		else
		begin
			errors++;
			$display("%s: more output beats than consumer credits", testName);
		end

	task automatic sendVector(input logic [numInputs*actWidth-1:0] vec);
		while (sendCredits <= 0)
		begin
			@(posedge clk);
			#1;
		end
		inValid = 1'b1;
		inVector = vec;
		expQ.push_back(modelNet(vec));
		sent++;
		@(posedge clk);
		#1;
		inValid = 1'b0;
		inVector = '0;
	endtask

	task automatic startTest(input string name);
		testName = name;
		errorsAtStart = errors;
	endtask

	task automatic finishTest();
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#1;
		inputCredits: assert (creditPulses == sent)
			else
			begin
				errors++;
				$display("ERROR %s: expected %0d inCredit pulses actual %0d", testName, sent,
					creditPulses);
			end
		if (errors == errorsAtStart)
		begin
			passCount++;
			$display("PASS %s", testName);
		end
		else
		begin
			failCount++;
			$display("FAIL %s with %0d errors", testName, errors - errorsAtStart);
		end
	endtask

	initial
	begin
		startTest("resetState");
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		finishTest();

		startTest("arithmetic");
		sendVector('0); // Bias only.
		for (int i = 0; i < numInputs; i++)
			sendVector(64'h40 << (i * actWidth));
		sendVector(64'h0102_0304_0506_0708);
		sendVector(64'hf010_e020_d030_c040);
		finishTest();

		startTest("rectifierEdges");
		sendVector({8{8'h80}});
		sendVector({8{8'h7f}});
		sendVector(64'h7f80_7f80_7f80_7f80);
		sendVector(64'h0303_0303_0303_0303);
		sendVector(64'h0201_0102_0201_0102);
		finishTest();

		startTest("inputCredits");
		for (int i = 0; i < inputDepth; i++)
			sendVector({$random(seed), $random(seed)});
		finishTest();

		startTest("backPressure");
		holdCredits = 1'b1;
		for (int i = 0; i < 8; i++)
			sendVector({$random(seed), $random(seed)});
		repeat (50) @(posedge clk);
		#1;
		holdCredits = 1'b0;
		finishTest();

		startTest("randomStream");
		randomCredits = 1'b1;
		for (int i = 0; i < 60; i++)
		begin
			if (($random(seed) & 3) == 0)
			begin
				@(posedge clk);
				#1;
			end
			sendVector({$random(seed), $random(seed)});
		end
		finishTest();
		randomCredits = 1'b0;

		$display("Tests passed %0d, failed %0d, assertion errors %0d", passCount, failCount, errors);
		if (failCount == 0 && errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end
endmodule

//--- files.f
+incdir+verification
logic/nnPkg.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/inputQueue.sv
logic/outputStage.sv
logic/neuralNet.sv
verification/neuralNetTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module neuralNetTb -f files.f
./obj_dir/VneuralNetTb > sim.log
cat sim.log

# The simulation result decides the exit status.
grep -q "^Verification passed$" sim.log
echo "Simulation passed"
